//--- design/uart_pkg.sv
// shared bus types, response codes and register offsets for the console path.
package uart_pkg;

	// ##########################################################################
	// bus field types
	// ##########################################################################

	typedef logic [31:0] addr_t; // byte address on the write bus.
	typedef logic [31:0] data_t; // one write data word.
	typedef logic [3:0]  strb_t; // one strobe bit per byte lane of data_t.
	typedef logic [1:0]  resp_t; // write response code.

	// one character as it goes out on the serial line.
	typedef logic [7:0] byte_t;

	// ##########################################################################
	// response codes
	// ##########################################################################

	// only the two codes the slave can produce are listed.
	// exokay and decerr never appear on this bus.
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// ##########################################################################
	// register map
	// ##########################################################################

	// the uart has a single write-only register.
	// the slave adds this offset to its base address when it decodes a write.
	localparam addr_t TXDATA_OFFSET = 32'h0000_0000; // transmit data, byte lane 0.

	// byte lane that carries the character inside a data word.
	// bits 31:8 of the word are ignored on a transmit write.
	localparam int TXDATA_LANE = 0;

	// a frame is start, eight data bits and stop.
	localparam int FRAME_BITS = 10;

endpackage

//--- design/axil_write_if.sv
// axi-lite write channels (aw, w, b) bundled as one interface.
`timescale 1ns/1ps

interface axil_write_if import uart_pkg::*; ();

	addr_t awaddr;  // write address.
	logic  awvalid;
	logic  awready;

	data_t wdata;   // write data.
	strb_t wstrb;   // byte strobes for wdata.
	logic  wvalid;
	logic  wready;

	resp_t bresp;   // write response code.
	logic  bvalid;
	logic  bready;

	// the side that starts transactions.
	modport manager (
		output awaddr, awvalid, wdata, wstrb, wvalid, bready,
		input  awready, wready, bresp, bvalid
	);

	// the side that answers them.
	modport subordinate (
		input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
		output awready, wready, bresp, bvalid
	);

endinterface

//--- design/axil_write_arbiter.sv
// round-robin arbiter that merges two axi-lite write masters onto one shared bus.
`timescale 1ns/1ps

module axil_write_arbiter (
	input logic                   clk,
	input logic                   rst,
	axil_write_if.subordinate     m0,
	axil_write_if.subordinate     m1,
	axil_write_if.manager         slv
);

	// ##########################################################################
	// grant state
	// ##########################################################################

	logic busy; // a master owns the bus until its b handshake.
	logic gnt;  // owner of the bus while busy, 0 for m0 and 1 for m1.
	logic ptr;  // master that wins when both request at once.
	logic pick; // master chosen on the granting edge.
	logic sel0;
	logic sel1;
	logic b_fire;

	// a lone requester always wins.
	// on a tie the pointer decides.
	assign pick = (m0.awvalid && m1.awvalid) ? ptr : m1.awvalid;

	assign sel0 = busy & ~gnt;
	assign sel1 = busy & gnt;

	assign b_fire = busy & slv.bvalid & slv.bready; // end of the granted transaction.

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			gnt  <= 1'b0;
			ptr  <= 1'b0; // m0 has priority after reset.
		end else if (!busy) begin
			if (m0.awvalid || m1.awvalid) begin
				busy <= 1'b1;
				gnt  <= pick;
			end
		end else if (b_fire) begin
			busy <= 1'b0;
			ptr  <= ~gnt; // the other master goes first next time.
		end
	end

	// ##########################################################################
	// forward path, granted master to slave
	// ##########################################################################

	// payload follows the grant.
	// the valids and bready are gated so nothing leaks out before a grant.
	assign slv.awaddr  = gnt ? m1.awaddr : m0.awaddr;
	assign slv.awvalid = busy & (gnt ? m1.awvalid : m0.awvalid);

	assign slv.wdata   = gnt ? m1.wdata : m0.wdata;
	assign slv.wstrb   = gnt ? m1.wstrb : m0.wstrb;
	assign slv.wvalid  = busy & (gnt ? m1.wvalid : m0.wvalid);

	assign slv.bready  = busy & (gnt ? m1.bready : m0.bready);

	// ##########################################################################
	// return path, slave to masters
	// ##########################################################################

	// the master that is not granted sees every ready and valid low.
	assign m0.awready = sel0 & slv.awready;
	assign m0.wready  = sel0 & slv.wready;
	assign m0.bvalid  = sel0 & slv.bvalid;
	assign m0.bresp   = slv.bresp; // only meaningful with bvalid.

	assign m1.awready = sel1 & slv.awready;
	assign m1.wready  = sel1 & slv.wready;
	assign m1.bvalid  = sel1 & slv.bvalid;
	assign m1.bresp   = slv.bresp;

endmodule

//--- design/uart_axil_slave.sv
// axi-lite write slave for the uart data register, with credit tracking of the tx queue.
`timescale 1ns/1ps

module uart_axil_slave import uart_pkg::*; #(
	parameter addr_t BASE_ADDR = 32'h1000_0000,
	parameter int    TX_DEPTH  = 4
) (
	input  logic              clk,
	input  logic              rst,
	axil_write_if.subordinate bus,
	output logic              push,
	output byte_t             push_byte,
	input  logic              credit_return
);

	localparam int CRED_W = $clog2(TX_DEPTH + 1);

	typedef enum logic [1:0] {
		ST_IDLE, // waiting for a routed request and a free queue slot.
		ST_ADDR, // awready high.
		ST_DATA, // wready high.
		ST_RESP  // bvalid high until bready.
	} wr_state_t;

	wr_state_t         state;
	logic              awready_q;
	logic              wready_q;
	logic              bvalid_q;
	resp_t             bresp_q;
	addr_t             awaddr_q;
	logic [CRED_W-1:0] credits;

	logic  aw_fire;
	logic  w_fire;
	logic  b_fire;
	logic  addr_hit;
	resp_t resp_code;

	assign bus.awready = awready_q;
	assign bus.wready  = wready_q;
	assign bus.bvalid  = bvalid_q;
	assign bus.bresp   = bresp_q;

	assign aw_fire = bus.awvalid & awready_q;
	assign w_fire  = bus.wvalid & wready_q;
	assign b_fire  = bvalid_q & bus.bready;

	// ##########################################################################
	// address decode
	// ##########################################################################

	assign addr_hit  = (awaddr_q == BASE_ADDR + TXDATA_OFFSET);
	assign resp_code = addr_hit ? RESP_OKAY : RESP_SLVERR;

	// a hit with lane 0 cleared is still okay, it just sends nothing.
	assign push      = w_fire & addr_hit & bus.wstrb[TXDATA_LANE];
	assign push_byte = bus.wdata[7:0];

	// ##########################################################################
	// write fsm
	// ##########################################################################

	// the ready and valid outputs are registers, set on the edge that enters
	// the state in which they are high.
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_IDLE;
			awready_q <= 1'b0;
			wready_q  <= 1'b0;
			bvalid_q  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// with no credit left the request simply waits here.
					if (bus.awvalid && credits != '0) begin
						awready_q <= 1'b1;
						state     <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (aw_fire) begin
						awready_q <= 1'b0;
						wready_q  <= 1'b1;
						state     <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (w_fire) begin
						wready_q <= 1'b0;
						bvalid_q <= 1'b1;
						state    <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (b_fire) begin
						bvalid_q <= 1'b0;
						state    <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire)
			awaddr_q <= bus.awaddr;
		if (w_fire)
			bresp_q <= resp_code; // held stable while bvalid waits.
	end

	// ##########################################################################
	// queue credits
	// ##########################################################################

	// one credit per free slot in the serializer queue.
	// a push and a return can land in the same cycle and then cancel out.
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CRED_W'(TX_DEPTH);
		end else begin
			case ({push, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

//--- design/uart_tx_serializer.sv
// transmit queue and 8n1 serializer that returns one credit per byte it pops.
`timescale 1ns/1ps

module uart_tx_serializer import uart_pkg::*; #(
	parameter int TX_DEPTH     = 4,
	parameter int CLKS_PER_BIT = 4
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  push,
	input  byte_t push_byte,
	output logic  credit_return,
	output logic  tx
);

	localparam int IDX_W = $clog2(TX_DEPTH);
	localparam int PTR_W = IDX_W + 1; // extra wrap bit tells full from empty.
	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} frame_state_t;

	// ##########################################################################
	// transmit queue
	// ##########################################################################

	byte_t            queue_mem [TX_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             empty;
	logic             pop;

	assign empty = (wr_ptr == rd_ptr);

	// the slave only pushes when it holds a credit, so the queue never overflows.
	always_ff @(posedge clk) begin
		if (push)
			queue_mem[wr_ptr[IDX_W-1:0]] <= push_byte;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// ##########################################################################
	// frame fsm
	// ##########################################################################

	frame_state_t     state;
	logic [CNT_W-1:0] bit_cnt;  // clocks spent in the current bit.
	logic [2:0]       bit_idx;  // data bit being sent.
	byte_t            shift_q;  // remaining data bits, lsb goes next.
	logic             tx_q;
	logic             bit_end;

	assign bit_end = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));

	// pop from idle, or straight out of the last stop clock so frames run back to back.
	assign pop = !empty && (state == ST_IDLE || (state == ST_STOP && bit_end));
	assign credit_return = pop;
	assign tx            = tx_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= ST_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			tx_q    <= 1'b1; // line idles high.
		end else begin
			if (pop) begin
				shift_q <= queue_mem[rd_ptr[IDX_W-1:0]];
				tx_q    <= 1'b0; // start bit.
				bit_cnt <= '0;
				state   <= ST_START;
			end else if (state != ST_IDLE) begin
				bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
				if (bit_end) begin
					case (state)
						ST_START: begin
							tx_q    <= shift_q[0];
							shift_q <= shift_q >> 1;
							bit_idx <= '0;
							state   <= ST_DATA;
						end
						ST_DATA: begin
							if (bit_idx == 3'd7) begin
								tx_q  <= 1'b1; // stop bit.
								state <= ST_STOP;
							end else begin
								tx_q    <= shift_q[0];
								shift_q <= shift_q >> 1;
								bit_idx <= bit_idx + 1'b1;
							end
						end
						default: state <= ST_IDLE; // end of stop bit, queue empty.
					endcase
				end
			end
		end
	end

endmodule

//--- design/uart_subsystem.sv
// console path top level: two axi-lite write masters, arbiter, uart slave and tx serializer.
`timescale 1ns/1ps

module uart_subsystem import uart_pkg::*; #(
	parameter addr_t BASE_ADDR    = 32'h1000_0000,
	parameter int    TX_DEPTH     = 4,
	parameter int    CLKS_PER_BIT = 4
) (
	input  logic  clk,
	input  logic  rst,
	// master 0, the core load/store unit.
	input  addr_t m0_awaddr,
	input  logic  m0_awvalid,
	output logic  m0_awready,
	input  data_t m0_wdata,
	input  strb_t m0_wstrb,
	input  logic  m0_wvalid,
	output logic  m0_wready,
	output resp_t m0_bresp,
	output logic  m0_bvalid,
	input  logic  m0_bready,
	// master 1, the debug writer.
	input  addr_t m1_awaddr,
	input  logic  m1_awvalid,
	output logic  m1_awready,
	input  data_t m1_wdata,
	input  strb_t m1_wstrb,
	input  logic  m1_wvalid,
	output logic  m1_wready,
	output resp_t m1_bresp,
	output logic  m1_bvalid,
	input  logic  m1_bready,
	output logic  tx
);

	axil_write_if m0_bus ();
	axil_write_if m1_bus ();
	axil_write_if slv_bus ();

	logic  push;
	byte_t push_byte;
	logic  credit_return;

	// ##########################################################################
	// master ports onto the interfaces
	// ##########################################################################

	assign m0_bus.awaddr  = m0_awaddr;
	assign m0_bus.awvalid = m0_awvalid;
	assign m0_bus.wdata   = m0_wdata;
	assign m0_bus.wstrb   = m0_wstrb;
	assign m0_bus.wvalid  = m0_wvalid;
	assign m0_bus.bready  = m0_bready;
	assign m0_awready     = m0_bus.awready;
	assign m0_wready      = m0_bus.wready;
	assign m0_bresp       = m0_bus.bresp;
	assign m0_bvalid      = m0_bus.bvalid;

	assign m1_bus.awaddr  = m1_awaddr;
	assign m1_bus.awvalid = m1_awvalid;
	assign m1_bus.wdata   = m1_wdata;
	assign m1_bus.wstrb   = m1_wstrb;
	assign m1_bus.wvalid  = m1_wvalid;
	assign m1_bus.bready  = m1_bready;
	assign m1_awready     = m1_bus.awready;
	assign m1_wready      = m1_bus.wready;
	assign m1_bresp       = m1_bus.bresp;
	assign m1_bvalid      = m1_bus.bvalid;

	// ##########################################################################
	// blocks
	// ##########################################################################

	axil_write_arbiter i_arbiter (
		.clk (clk),
		.rst (rst),
		.m0  (m0_bus),
		.m1  (m1_bus),
		.slv (slv_bus)
	);

	uart_axil_slave #(
		.BASE_ADDR (BASE_ADDR),
		.TX_DEPTH  (TX_DEPTH)
	) i_slave (
		.clk           (clk),
		.rst           (rst),
		.bus           (slv_bus),
		.push          (push),
		.push_byte     (push_byte),
		.credit_return (credit_return)
	);

	uart_tx_serializer #(
		.TX_DEPTH     (TX_DEPTH),
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_serializer (
		.clk           (clk),
		.rst           (rst),
		.push          (push),
		.push_byte     (push_byte),
		.credit_return (credit_return),
		.tx            (tx)
	);

endmodule

//--- verification/tb_uart_subsystem.sv
// directed testbench for the console path, with bus drivers, a tx line monitor and a timeout.
`timescale 1ns/1ps

module tb_uart_subsystem import uart_pkg::*; ();

	localparam addr_t BASE_ADDR    = 32'h1000_0000;
	localparam int    TX_DEPTH     = 4;
	localparam int    CLKS_PER_BIT = 4;

	// four frames from the pairs, one single, one after the rejects, ten in the burst,
	// two in the held response test.
	localparam int TOTAL_FRAMES = 18;
	localparam int CYCLE_LIMIT  = (TOTAL_FRAMES + 2) * FRAME_BITS * CLKS_PER_BIT + 500;

	logic  clk;
	logic  rst;
	addr_t awaddr  [2]; // index 0 is m0, index 1 is m1.
	logic  awvalid [2];
	logic  awready [2];
	data_t wdata   [2];
	strb_t wstrb   [2];
	logic  wvalid  [2];
	logic  wready  [2];
	resp_t bresp   [2];
	logic  bvalid  [2];
	logic  bready  [2];
	logic  tx;

	byte_t       expected_bytes [$]; // bytes still to appear on tx, in order.
	logic [31:0] lfsr_state;

	uart_subsystem #(
		.BASE_ADDR    (BASE_ADDR),
		.TX_DEPTH     (TX_DEPTH),
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_uart_subsystem (
		.clk        (clk),
		.rst        (rst),
		.m0_awaddr  (awaddr[0]),
		.m0_awvalid (awvalid[0]),
		.m0_awready (awready[0]),
		.m0_wdata   (wdata[0]),
		.m0_wstrb   (wstrb[0]),
		.m0_wvalid  (wvalid[0]),
		.m0_wready  (wready[0]),
		.m0_bresp   (bresp[0]),
		.m0_bvalid  (bvalid[0]),
		.m0_bready  (bready[0]),
		.m1_awaddr  (awaddr[1]),
		.m1_awvalid (awvalid[1]),
		.m1_awready (awready[1]),
		.m1_wdata   (wdata[1]),
		.m1_wstrb   (wstrb[1]),
		.m1_wvalid  (wvalid[1]),
		.m1_wready  (wready[1]),
		.m1_bresp   (bresp[1]),
		.m1_bvalid  (bvalid[1]),
		.m1_bready  (bready[1]),
		.tx         (tx)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ##########################################################################
	// helpers
	// ##########################################################################

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			$display("ERRORS FOUND");
			$fatal(1, "value check failed");
		end
	endtask

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken.
	function automatic byte_t next_byte();
		byte_t b;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			b[i] = lfsr_state[0];
		end
		return b;
	endfunction

	// Starts and ends on a rising edge. Reads after an edge see the values the DUT sampled.
	task automatic axil_write(input int m, input addr_t addr, input data_t data,
			input strb_t strb, input int bready_delay, output resp_t resp);
		resp_t held;
		awaddr[m]  <= addr;
		awvalid[m] <= 1'b1;
		wdata[m]   <= data;
		wstrb[m]   <= strb;
		wvalid[m]  <= 1'b1;
		bready[m]  <= 1'b0;
		@(posedge clk);
		while (!awready[m]) @(posedge clk);
		awvalid[m] <= 1'b0;
		@(posedge clk);
		while (!wready[m]) @(posedge clk);
		wvalid[m] <= 1'b0;
		@(posedge clk);
		while (!bvalid[m]) @(posedge clk);
		held = bresp[m];
		repeat (bready_delay) begin
			check_equal(32'(bvalid[m]), 32'd1, "bvalid held until bready");
			check_equal(32'(bresp[m]), 32'(held), "bresp stable while bvalid waits");
			check_equal(32'(awready[1 - m]), 32'd0, "other master awready while bus held");
			check_equal(32'(wready[1 - m]), 32'd0, "other master wready while bus held");
			check_equal(32'(bvalid[1 - m]), 32'd0, "other master bvalid while bus held");
			@(posedge clk);
		end
		bready[m] <= 1'b1;
		@(posedge clk);
		while (!bvalid[m]) @(posedge clk);
		bready[m] <= 1'b0;
		resp = held;
	endtask

	task automatic wait_tx_drain();
		while (expected_bytes.size() != 0) @(posedge clk);
	endtask

	// every ready and valid back to the masters is low and the line idles high.
	task automatic check_reset_state();
		for (int i = 0; i < 2; i++) begin
			check_equal(32'(awready[i]), 32'd0, "awready after reset");
			check_equal(32'(wready[i]), 32'd0, "wready after reset");
			check_equal(32'(bvalid[i]), 32'd0, "bvalid after reset");
		end
		check_equal(32'(tx), 32'd1, "tx level after reset");
	endtask

	// ##########################################################################
	// tx line monitor
	// ##########################################################################

	initial begin : tx_monitor
		byte_t got;
		@(negedge rst);
		forever begin
			@(negedge tx);
			repeat (CLKS_PER_BIT / 2) @(posedge clk); // middle of the start bit.
			check_equal(32'(tx), 32'd0, "start bit");
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(posedge clk);
				got[i] = tx; // lsb first.
			end
			repeat (CLKS_PER_BIT) @(posedge clk);
			check_equal(32'(tx), 32'd1, "stop bit");
			if (expected_bytes.size() == 0) begin
				$display("tx sent byte %0h at %0t ns but no write produced it", got, $time);
				$display("ERRORS FOUND");
				$fatal(1, "unexpected frame");
			end else begin
				check_equal(32'(got), 32'(expected_bytes.pop_front()), "tx byte order");
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= CYCLE_LIMIT) begin
				$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
				$display("ERRORS FOUND");
				$fatal(1, "timeout");
			end
		end
	end

	// ##########################################################################
	// tests
	// ##########################################################################

	task automatic single_write();
		byte_t b;
		resp_t r;
		b = next_byte();
		expected_bytes.push_back(b);
		axil_write(0, BASE_ADDR, {24'h0, b}, 4'h1, 0, r);
		check_equal(32'(r), 32'(RESP_OKAY), "single write response");
		wait_tx_drain();
	endtask

	// two tied pairs; m0 wins both, since m1 hands the pointer back.
	task automatic simultaneous_pairs();
		byte_t b0;
		byte_t b1;
		resp_t r0;
		resp_t r1;
		for (int p = 0; p < 2; p++) begin
			b0 = next_byte();
			b1 = next_byte();
			expected_bytes.push_back(b0);
			expected_bytes.push_back(b1);
			fork
				axil_write(0, BASE_ADDR, {24'h0, b0}, 4'h1, 0, r0);
				axil_write(1, BASE_ADDR, {24'h0, b1}, 4'h1, 0, r1);
			join
			check_equal(32'(r0), 32'(RESP_OKAY), "m0 response in tied pair");
			check_equal(32'(r1), 32'(RESP_OKAY), "m1 response in tied pair");
		end
		wait_tx_drain();
	endtask

	task automatic rejected_writes();
		byte_t b;
		resp_t r;
		axil_write(0, BASE_ADDR + 32'h4, {24'h0, next_byte()}, 4'h1, 0, r);
		check_equal(32'(r), 32'(RESP_SLVERR), "write to unmapped offset");
		axil_write(0, BASE_ADDR, {24'h0, next_byte()}, 4'he, 0, r); // lane 0 off.
		check_equal(32'(r), 32'(RESP_OKAY), "write with lane 0 strobe clear");
		b = next_byte();
		expected_bytes.push_back(b);
		axil_write(0, BASE_ADDR, {24'h0, b}, 4'h1, 0, r);
		check_equal(32'(r), 32'(RESP_OKAY), "valid write after rejects");
		wait_tx_drain();
	endtask

	task automatic burst_backpressure();
		byte_t b;
		resp_t r;
		for (int i = 0; i < 10; i++) begin
			b = next_byte();
			expected_bytes.push_back(b);
			axil_write(1, BASE_ADDR, {24'h0, b}, 4'h1, 0, r);
			check_equal(32'(r), 32'(RESP_OKAY), "burst write response");
		end
		wait_tx_drain();
	endtask

	task automatic held_response();
		byte_t b0;
		byte_t b1;
		resp_t r0;
		resp_t r1;
		b0 = next_byte();
		b1 = next_byte();
		expected_bytes.push_back(b0);
		expected_bytes.push_back(b1);
		fork
			axil_write(0, BASE_ADDR, {24'h0, b0}, 4'h1, 8, r0);
			begin
				@(posedge clk); // m1 arrives once m0 owns the bus.
				axil_write(1, BASE_ADDR, {24'h0, b1}, 4'h1, 0, r1);
			end
		join
		check_equal(32'(r0), 32'(RESP_OKAY), "m0 held response");
		check_equal(32'(r1), 32'(RESP_OKAY), "m1 write behind held response");
	endtask

	initial begin
		lfsr_state = 32'h9ba3;
		rst <= 1'b1;
		for (int i = 0; i < 2; i++) begin
			awaddr[i]  <= '0;
			awvalid[i] <= 1'b0;
			wdata[i]   <= '0;
			wstrb[i]   <= '0;
			wvalid[i]  <= 1'b0;
			bready[i]  <= 1'b0;
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		check_reset_state();
		simultaneous_pairs(); // needs the pointer as it is after reset.
		single_write();
		rejected_writes();
		burst_backpressure();
		held_response();
		// the last two frames go out here, with room left for a stray one.
		repeat (3 * FRAME_BITS * CLKS_PER_BIT) @(posedge clk);
		if (expected_bytes.size() != 0) begin
			$display("%0d expected bytes never appeared on tx", expected_bytes.size());
			$display("ERRORS FOUND");
			$fatal(1, "bytes missing at end of run");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

//--- filelist.f
design/uart_pkg.sv
design/axil_write_if.sv
design/axil_write_arbiter.sv
design/uart_axil_slave.sv
design/uart_tx_serializer.sv
design/uart_subsystem.sv
verification/tb_uart_subsystem.sv

//--- Makefile
# Verilator build and run of the console path testbench.

VERILATOR ?= verilator
TOP       ?= tb_uart_subsystem
FILELIST  ?= filelist.f
BUILD_DIR ?= build

.PHONY: sim clean

# The run exits with a failing status on any $fatal.
sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
